//--- Makefile
# Verilator build and run of the data cache testbench

TOP := tb_std_dcache

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f std_dcache.f -Mdir obj_dir -o V$(TOP)

# exit status of the simulation is the test result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hw/cache_ctrl.sv
// write-through cache controller FSM with saved request and miss and bypass request generation
`timescale 1ns/1ps

module cache_ctrl
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_WAYS = 2,
  parameter int unsigned NUM_SETS = 16,
  localparam int unsigned OFFSET_W   = $clog2(LINE_WIDTH / 8),
  localparam int unsigned INDEX_W    = $clog2(NUM_SETS),
  localparam int unsigned TAG_W      = ADDR_WIDTH - INDEX_W - OFFSET_W,
  localparam int unsigned WORD_OFF_W = $clog2(WORDS_PER_LINE),
  localparam int unsigned LINE_BYTES = LINE_WIDTH / 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  bypass_i,
  // core side
  input  core_req_t             req_i,
  output core_rsp_t             rsp_o,
  // tag and data store results, one cycle after rd_en_o
  input  logic [NUM_WAYS-1:0]   hit_way_i,
  input  logic [NUM_WAYS-1:0]   victim_way_i,
  input  word_t                 rd_word_i,
  // miss unit
  output miss_req_t             miss_req_o,
  input  logic                  miss_gnt_i,
  input  logic                  bypass_gnt_i,
  input  logic                  refill_valid_i,
  input  cache_line_u           refill_line_i,
  input  logic                  bypass_valid_i,
  input  word_t                 bypass_data_i,
  // array read port
  output logic                  rd_en_o,
  output logic [INDEX_W-1:0]    rd_index_o,
  output logic [WORD_OFF_W-1:0] rd_offset_o,
  // array write port
  output logic                  wr_en_o,
  output logic [NUM_WAYS-1:0]   wr_way_o,
  output logic [INDEX_W-1:0]    wr_index_o,
  output cache_line_u           wr_line_o,
  output logic [LINE_BYTES-1:0] wr_be_o,
  output logic                  tag_wr_o,
  output logic [TAG_W-1:0]      wr_tag_o,
  // observation
  output logic                  busy_o,
  output logic                  hit_o
);

  localparam int unsigned WORD_LSB = $clog2(WORD_WIDTH / 8);
  localparam int unsigned BE_W     = WORD_WIDTH / 8;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    WRITE_THROUGH,
    MISS_REQ,
    WAIT_REFILL,
    BYPASS_REQ,
    BYPASS_WAIT
  } state_e;

  // request as accepted from the core
  typedef struct packed {
    logic  bypass;
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
  } saved_req_t;

  state_e              state_d, state_q;
  saved_req_t          req_d, req_q;
  // hit way for a store, victim way for a refill
  logic [NUM_WAYS-1:0] way_d, way_q;

  assign busy_o      = (state_q != IDLE);
  // index and offset go straight from the core so the arrays read in the accept cycle
  assign rd_index_o  = req_i.addr[OFFSET_W +: INDEX_W];
  assign rd_offset_o = req_i.addr[WORD_LSB +: WORD_OFF_W];
  // saved tag serves both as compare tag and refill tag
  assign wr_tag_o    = req_q.addr[ADDR_WIDTH-1 -: TAG_W];

  // --------------------
  // cache FSM
  // --------------------
  always_comb begin : ctrl_fsm
    logic [WORD_OFF_W-1:0] word_off;
    logic                  accept_ok;

    word_off  = req_q.addr[WORD_LSB +: WORD_OFF_W];
    accept_ok = 1'b0;

    state_d = state_q;
    req_d   = req_q;
    way_d   = way_q;

    rsp_o   = '0;
    hit_o   = 1'b0;
    rd_en_o = 1'b0;

    // payload always follows the saved request, valid is set per state
    miss_req_o        = '0;
    miss_req_o.bypass = req_q.bypass;
    miss_req_o.we     = req_q.we;
    miss_req_o.addr   = req_q.addr;
    miss_req_o.be     = req_q.be;
    miss_req_o.wdata  = req_q.wdata;

    wr_en_o    = 1'b0;
    tag_wr_o   = 1'b0;
    wr_way_o   = way_q;
    wr_index_o = req_q.addr[OFFSET_W +: INDEX_W];
    wr_line_o  = '0;
    wr_be_o    = '0;

    case (state_q)
      IDLE: begin
        accept_ok = 1'b1;
      end

      // tags and data of the saved index are valid now
      LOOKUP: begin
        if (|hit_way_i) begin
          if (!req_q.we) begin
            hit_o             = 1'b1;
            rsp_o.data_rvalid = 1'b1;
            rsp_o.data_rdata  = rd_word_i;
            state_d           = IDLE;
            // next load may be taken while this one returns
            accept_ok         = 1'b1;
          end else begin
            way_d   = hit_way_i;
            state_d = STORE_WRITE;
          end
        end else if (req_q.we) begin
          // store miss, no allocation
          state_d = WRITE_THROUGH;
        end else begin
          way_d   = victim_way_i;
          state_d = MISS_REQ;
        end
      end

      // merge store word into the hit line
      STORE_WRITE: begin
        wr_en_o = 1'b1;
        for (int unsigned i = 0; i < WORDS_PER_LINE; i++) begin
          wr_line_o.words[i] = req_q.wdata;
        end
        wr_be_o[word_off*BE_W +: BE_W] = req_q.be;
        state_d = WRITE_THROUGH;
      end

      // memory write, store is granted when it is taken
      WRITE_THROUGH: begin
        miss_req_o.valid = 1'b1;
        if (miss_gnt_i) begin
          rsp_o.data_gnt = 1'b1;
          state_d        = IDLE;
        end
      end

      MISS_REQ: begin
        miss_req_o.valid = 1'b1;
        if (miss_gnt_i) begin
          state_d = WAIT_REFILL;
        end
      end

      // whole line goes into the victim way, critical word to the core
      WAIT_REFILL: begin
        if (refill_valid_i) begin
          wr_en_o           = 1'b1;
          tag_wr_o          = 1'b1;
          wr_line_o         = refill_line_i;
          wr_be_o           = '1;
          rsp_o.data_rvalid = 1'b1;
          rsp_o.data_rdata  = refill_line_i.words[word_off];
          state_d           = IDLE;
        end
      end

      BYPASS_REQ: begin
        miss_req_o.valid = 1'b1;
        if (bypass_gnt_i) begin
          if (req_q.we) begin
            rsp_o.data_gnt = 1'b1;
            state_d        = IDLE;
          end else begin
            state_d = BYPASS_WAIT;
          end
        end
      end

      BYPASS_WAIT: begin
        if (bypass_valid_i) begin
          rsp_o.data_rvalid = 1'b1;
          rsp_o.data_rdata  = bypass_data_i;
          state_d           = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // --------------------
    // new request
    // --------------------
    if (accept_ok && req_i.data_req) begin
      req_d.bypass = bypass_i;
      req_d.we     = req_i.we;
      req_d.addr   = req_i.addr;
      req_d.be     = req_i.be;
      req_d.wdata  = req_i.wdata;
      // loads are granted here, stores once memory takes them
      rsp_o.data_gnt = !req_i.we;
      if (bypass_i) begin
        state_d = BYPASS_REQ;
      end else begin
        rd_en_o = 1'b1;
        state_d = LOOKUP;
      end
    end
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q <= req_d;
    way_q <= way_d;
  end

endmodule

//--- hw/data_store.sv
// line arrays per way with byte-enable writes and hit-way word select
`timescale 1ns/1ps

module data_store
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_WAYS = 2,
  parameter int unsigned NUM_SETS = 16,
  localparam int unsigned INDEX_W    = $clog2(NUM_SETS),
  localparam int unsigned WORD_OFF_W = $clog2(WORDS_PER_LINE),
  localparam int unsigned LINE_BYTES = LINE_WIDTH / 8
) (
  input  logic                  clk_i,
  input  logic                  rd_en_i,
  input  logic [INDEX_W-1:0]    rd_index_i,
  input  logic [WORD_OFF_W-1:0] rd_offset_i,
  input  logic [NUM_WAYS-1:0]   hit_way_i,
  input  logic                  wr_en_i,
  input  logic [NUM_WAYS-1:0]   wr_way_i,
  input  logic [INDEX_W-1:0]    wr_index_i,
  input  cache_line_u           wr_line_i,
  input  logic [LINE_BYTES-1:0] wr_be_i,
  output word_t                 rd_word_o
);

  cache_line_u                        lines_q [NUM_WAYS][NUM_SETS];
  // whole set as read one cycle after rd_en_i
  cache_line_u [NUM_WAYS-1:0]         rd_lines_q;
  logic        [WORD_OFF_W-1:0]       rd_offset_q;

  // --------------------
  // array access
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int unsigned w = 0; w < NUM_WAYS; w++) begin
        rd_lines_q[w] <= lines_q[w][rd_index_i];
      end
      rd_offset_q <= rd_offset_i;
    end
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      for (int unsigned b = 0; b < LINE_BYTES; b++) begin
        if (wr_en_i && wr_way_i[w] && wr_be_i[b]) begin
          lines_q[w][wr_index_i].raw[b*8 +: 8] <= wr_line_i.raw[b*8 +: 8];
        end
      end
    end
  end

  // hit way is one-hot, so OR of the selected words
  always_comb begin
    rd_word_o = '0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (hit_way_i[w]) begin
        rd_word_o = rd_word_o | rd_lines_q[w].words[rd_offset_q];
      end
    end
  end

endmodule

//--- hw/dcache_pkg.sv
// data cache widths, word and line types, core and miss request and response structs
package dcache_pkg;

  // --------------------
  // widths
  // --------------------
  // byte address
  localparam int unsigned ADDR_WIDTH     = 32;
  // one data word as seen by the core
  localparam int unsigned WORD_WIDTH     = 64;
  // one cache line as moved by a refill
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;

  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [WORD_WIDTH/8-1:0] be_t;

  // line as one raw vector for refill and arrays, or as words for select and merge
  typedef union packed {
    logic [LINE_WIDTH-1:0]      raw;
    word_t [WORDS_PER_LINE-1:0] words;
  } cache_line_u;

  // --------------------
  // core port
  // --------------------
  // data_req is held until data_gnt
  typedef struct packed {
    logic  data_req;
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
  } core_req_t;

  typedef struct packed {
    logic  data_gnt;
    logic  data_rvalid;
    word_t data_rdata;
  } core_rsp_t;

  // --------------------
  // miss unit port
  // --------------------
  // valid is held until miss_gnt or bypass_gnt
  typedef struct packed {
    logic  valid;
    logic  bypass;
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
  } miss_req_t;

endpackage

//--- hw/std_dcache.sv
// data cache top level with controller, tag store and data store
`timescale 1ns/1ps

module std_dcache
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_WAYS = 2,
  parameter int unsigned NUM_SETS = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        bypass_i,
  input  core_req_t   req_i,
  output core_rsp_t   rsp_o,
  output miss_req_t   miss_req_o,
  input  logic        miss_gnt_i,
  input  logic        bypass_gnt_i,
  input  logic        refill_valid_i,
  input  cache_line_u refill_line_i,
  input  logic        bypass_valid_i,
  input  word_t       bypass_data_i,
  output logic        busy_o,
  output logic        hit_o
);

  localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
  localparam int unsigned TAG_W      = ADDR_WIDTH - INDEX_W - $clog2(LINE_WIDTH / 8);
  localparam int unsigned WORD_OFF_W = $clog2(WORDS_PER_LINE);
  localparam int unsigned LINE_BYTES = LINE_WIDTH / 8;

  // read side
  logic                  rd_en;
  logic [INDEX_W-1:0]    rd_index;
  logic [WORD_OFF_W-1:0] rd_offset;
  logic [NUM_WAYS-1:0]   hit_way;
  logic [NUM_WAYS-1:0]   victim_way;
  word_t                 rd_word;
  // write side, shared by store merge and refill
  logic                  wr_en;
  logic [NUM_WAYS-1:0]   wr_way;
  logic [INDEX_W-1:0]    wr_index;
  cache_line_u           wr_line;
  logic [LINE_BYTES-1:0] wr_be;
  logic                  tag_wr;
  // saved tag, used for compare and for refill
  logic [TAG_W-1:0]      req_tag;

  cache_ctrl #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) i_cache_ctrl (
    .clk_i,
    .rst_ni,
    .bypass_i,
    .req_i,
    .rsp_o,
    .hit_way_i     (hit_way),
    .victim_way_i  (victim_way),
    .rd_word_i     (rd_word),
    .miss_req_o,
    .miss_gnt_i,
    .bypass_gnt_i,
    .refill_valid_i,
    .refill_line_i,
    .bypass_valid_i,
    .bypass_data_i,
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .rd_offset_o   (rd_offset),
    .wr_en_o       (wr_en),
    .wr_way_o      (wr_way),
    .wr_index_o    (wr_index),
    .wr_line_o     (wr_line),
    .wr_be_o       (wr_be),
    .tag_wr_o      (tag_wr),
    .wr_tag_o      (req_tag),
    .busy_o,
    .hit_o
  );

  tag_store #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) i_tag_store (
    .clk_i,
    .rst_ni,
    .rd_en_i      (rd_en),
    .rd_index_i   (rd_index),
    .cmp_tag_i    (req_tag),
    .wr_en_i      (tag_wr),
    .wr_way_i     (wr_way),
    .wr_index_i   (wr_index),
    .wr_tag_i     (req_tag),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  data_store #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) i_data_store (
    .clk_i,
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .rd_offset_i (rd_offset),
    .hit_way_i   (hit_way),
    .wr_en_i     (wr_en),
    .wr_way_i    (wr_way),
    .wr_index_i  (wr_index),
    .wr_line_i   (wr_line),
    .wr_be_i     (wr_be),
    .rd_word_o   (rd_word)
  );

endmodule

//--- hw/tag_store.sv
// valid and tag arrays per way with tag compare and round-robin victim choice
`timescale 1ns/1ps

module tag_store
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_WAYS = 2,
  parameter int unsigned NUM_SETS = 16,
  localparam int unsigned INDEX_W = $clog2(NUM_SETS),
  localparam int unsigned TAG_W   = ADDR_WIDTH - INDEX_W - $clog2(LINE_WIDTH / 8)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rd_en_i,
  input  logic [INDEX_W-1:0]  rd_index_i,
  input  logic [TAG_W-1:0]    cmp_tag_i,
  input  logic                wr_en_i,
  input  logic [NUM_WAYS-1:0] wr_way_i,
  input  logic [INDEX_W-1:0]  wr_index_i,
  input  logic [TAG_W-1:0]    wr_tag_i,
  output logic [NUM_WAYS-1:0] hit_way_o,
  output logic [NUM_WAYS-1:0] victim_way_o
);

  localparam int unsigned WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [TAG_W-1:0]    tags_q  [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  // round-robin pointer per set
  logic [WAY_W-1:0]    rr_q    [NUM_SETS];
  logic [INDEX_W-1:0]  index_q;

  // compare and victim both work on the index of the last read
  always_comb begin
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      hit_way_o[w] = valid_q[index_q][w] && (tags_q[w][index_q] == cmp_tag_i);
    end
    victim_way_o = '0;
    victim_way_o[rr_q[index_q]] = 1'b1;
    // an empty way wins over the pointer, lowest first
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[index_q][w]) begin
        victim_way_o    = '0;
        victim_way_o[w] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
      valid_q <= '{default: '0};
      rr_q    <= '{default: '0};
    end else begin
      if (rd_en_i) begin
        index_q <= rd_index_i;
      end
      if (wr_en_i) begin
        valid_q[wr_index_i] <= valid_q[wr_index_i] | wr_way_i;
        // step past the way just filled
        if (rr_q[wr_index_i] == WAY_W'(NUM_WAYS - 1)) begin
          rr_q[wr_index_i] <= '0;
        end else begin
          rr_q[wr_index_i] <= rr_q[wr_index_i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        tags_q[w][wr_index_i] <= wr_tag_i;
      end
    end
  end

endmodule

//--- std_dcache.f
hw/dcache_pkg.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/std_dcache.sv
verification/tb_clk_gen.sv
verification/std_dcache_sva.sv
verification/tb_std_dcache.sv

//--- verification/std_dcache_sva.sv
// concurrent port checks of the data cache, bound into the top level
`timescale 1ns/1ps

module std_dcache_sva
  import dcache_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      bypass_i,
  input core_req_t req_i,
  input core_rsp_t rsp_o,
  input miss_req_t miss_req_o,
  input logic      miss_gnt_i,
  input logic      bypass_gnt_i,
  input logic      hit_o
);

  logic load_pending_q;
  logic load_accept;
  logic req_taken;

  // a load is granted at accept, stores only at completion
  assign load_accept = rsp_o.data_gnt && req_i.data_req && !req_i.we;
  assign req_taken   = miss_req_o.bypass ? bypass_gnt_i : miss_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_pending_q <= 1'b0;
    end else if (load_accept) begin
      load_pending_q <= 1'b1;
    end else if (rsp_o.data_rvalid) begin
      load_pending_q <= 1'b0;
    end
  end

  // --------------------
  // properties
  // --------------------
  rvalid_needs_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.data_rvalid |-> load_pending_q)
    else $error("data_rvalid without an outstanding load");

  miss_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (miss_req_o.valid && !req_taken) |=> $stable(miss_req_o))
    else $error("miss request changed before its grant");

  // hit_o follows the accept cycle by one
  no_hit_in_bypass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit_o |-> !$past(bypass_i))
    else $error("hit_o pulsed for a request taken in bypass mode");

endmodule

//--- verification/tb_clk_gen.sv
// testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // release just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

//--- verification/tb_std_dcache.sv
// testbench top with core driver, miss unit and memory models, checks and timeout
`timescale 1ns/1ps

module tb_std_dcache
  import dcache_pkg::*;
();

  localparam int unsigned NUM_WAYS     = 2;
  localparam int unsigned NUM_SETS     = 16;
  localparam int unsigned RESET_CYCLES = 8;
  // 64 lines of two words, byte address bits 9:3
  localparam int unsigned MEM_WORDS    = 128;
  localparam int unsigned NUM_BYPASS   = 20;
  localparam int unsigned NUM_COLD     = 4;
  localparam int unsigned NUM_WARM     = 6;
  localparam int unsigned BURST_LEN    = 12;
  localparam int unsigned NUM_MIXED    = 300;
  // cold phase issues two loads, a store and a load per line
  localparam int unsigned TOTAL_REQS   = NUM_BYPASS + 4 * NUM_COLD + NUM_WARM + BURST_LEN
                                         + NUM_MIXED;
  localparam int unsigned TIMEOUT_CYCLES = 40 * TOTAL_REQS + RESET_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        bypass_mode;
  core_req_t   core_req;
  core_rsp_t   core_rsp;
  miss_req_t   miss_req;
  logic        miss_gnt;
  logic        bypass_gnt;
  logic        refill_valid;
  cache_line_u refill_line;
  logic        bypass_valid;
  word_t       bypass_data;
  logic        busy;
  logic        hit;

  // memory behind the miss unit, and the expected memory contents
  word_t       ext_mem [MEM_WORDS];
  word_t       ref_mem [MEM_WORDS];
  // requests taken by the miss unit, drained by the core side
  miss_req_t   granted_q [$];
  addr_t       burst_addr [BURST_LEN];

  tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  std_dcache #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .bypass_i       (bypass_mode),
    .req_i          (core_req),
    .rsp_o          (core_rsp),
    .miss_req_o     (miss_req),
    .miss_gnt_i     (miss_gnt),
    .bypass_gnt_i   (bypass_gnt),
    .refill_valid_i (refill_valid),
    .refill_line_i  (refill_line),
    .bypass_valid_i (bypass_valid),
    .bypass_data_i  (bypass_data),
    .busy_o         (busy),
    .hit_o          (hit)
  );

  bind std_dcache std_dcache_sva i_sva (
    .clk_i, .rst_ni, .bypass_i, .req_i, .rsp_o, .miss_req_o, .miss_gnt_i, .bypass_gnt_i, .hit_o
  );

  // --------------------
  // helpers
  // --------------------
  function automatic word_t fill_word(input int unsigned idx);
    return {idx ^ 32'hc3a5_0f00, idx * 32'h9e37_79b9};
  endfunction

  function automatic word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic int unsigned mem_index(input addr_t a);
    return 32'(a[9:3]);
  endfunction

  function automatic addr_t index_addr(input int unsigned idx);
    return addr_t'(idx) << 3;
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t wdata, input be_t be);
    word_t res;
    res = old;
    for (int unsigned b = 0; b < WORD_WIDTH / 8; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // miss request as the core port should produce it
  function automatic miss_req_t make_req(input logic we, input addr_t a, input be_t be,
                                         input word_t wdata);
    miss_req_t r;
    r        = '0;
    r.valid  = 1'b1;
    r.bypass = bypass_mode;
    r.we     = we;
    r.addr   = a;
    r.be     = be;
    r.wdata  = wdata;
    return r;
  endfunction

  function automatic string req_text(input miss_req_t r);
    return $sformatf("valid=%0b bypass=%0b we=%0b addr=%h be=%h wdata=%h",
                     r.valid, r.bypass, r.we, r.addr, r.be, r.wdata);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_miss_req(input string name, input miss_req_t exp, input miss_req_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected %s, actual %s", name, req_text(exp),
                               req_text(act)));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic expect_one_request(input string name, input miss_req_t exp);
    if (granted_q.size() != 1) begin
      report_failure($sformatf("%s sent %0d memory requests instead of one", name,
                               granted_q.size()));
    end
    check_miss_req(name, exp, granted_q.pop_front());
  endtask

  // --------------------
  // core side
  // --------------------
  // returns at the drive point of the cycle after data_gnt
  task automatic hold_until_grant();
    logic gnt;
    gnt = 1'b0;
    while (!gnt) begin
      @(negedge clk);
      gnt = core_rsp.data_gnt;
      @(posedge clk);
      #2;
    end
  endtask

  // lat counts cycles from the grant cycle to data_rvalid
  task automatic wait_for_data(output word_t data, output logic saw_hit,
                               output int unsigned lat);
    logic got;
    got = 1'b0;
    lat = 0;
    while (!got) begin
      @(negedge clk);
      lat++;
      if (core_rsp.data_rvalid) begin
        got     = 1'b1;
        data    = core_rsp.data_rdata;
        saw_hit = hit;
      end else begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic load_word(input string name, input addr_t addr, output logic saw_hit,
                           output int unsigned lat);
    word_t data;
    @(posedge clk);
    #2;
    // the previous request has fully ended
    check_bit({name, " busy before request"}, 1'b0, busy);
    core_req          = '0;
    core_req.data_req = 1'b1;
    core_req.addr     = addr;
    hold_until_grant();
    core_req = '0;
    wait_for_data(data, saw_hit, lat);
    // still busy in the cycle that returns the data
    check_bit({name, " busy at data"}, 1'b1, busy);
    check_word(name, ref_mem[mem_index(addr)], data);
    if (saw_hit) begin
      if (granted_q.size() != 0) begin
        report_failure($sformatf("%s hit the cache and still sent a memory request", name));
      end
    end else begin
      expect_one_request(name, make_req(1'b0, addr, '0, '0));
    end
  endtask

  task automatic store_word(input string name, input addr_t addr, input be_t be,
                            input word_t wdata);
    @(posedge clk);
    #2;
    check_bit({name, " busy before request"}, 1'b0, busy);
    core_req.data_req = 1'b1;
    core_req.we       = 1'b1;
    core_req.addr     = addr;
    core_req.be       = be;
    core_req.wdata    = wdata;
    hold_until_grant();
    core_req = '0;
    ref_mem[mem_index(addr)] = merge_bytes(ref_mem[mem_index(addr)], wdata, be);
    // write-through, so every store reaches memory exactly once
    expect_one_request(name, make_req(1'b1, addr, be, wdata));
  endtask

  // one load per cycle over burst_addr, all lines already cached
  task automatic load_burst(input string name);
    word_t       exp_words [$];
    int unsigned due [$];
    int unsigned next;
    int unsigned cyc;
    int unsigned exp_cyc;
    next = 0;
    cyc  = 0;
    @(posedge clk);
    #2;
    core_req.data_req = 1'b1;
    core_req.addr     = burst_addr[0];
    while (next < BURST_LEN || exp_words.size() != 0) begin
      @(negedge clk);
      // older load returns before the same-cycle grant is queued
      if (core_rsp.data_rvalid) begin
        if (exp_words.size() == 0) begin
          report_failure($sformatf("%s returned data with no load outstanding", name));
        end
        exp_cyc = due.pop_front();
        if (cyc != exp_cyc) begin
          report_failure($sformatf("Error %s: expected data in cycle %0d, actual cycle %0d",
                                   name, exp_cyc, cyc));
        end
        check_word(name, exp_words.pop_front(), core_rsp.data_rdata);
        if (!hit) begin
          report_failure($sformatf("%s missed on a line that was cached", name));
        end
      end
      if (next < BURST_LEN && core_rsp.data_gnt) begin
        exp_words.push_back(ref_mem[mem_index(burst_addr[next])]);
        due.push_back(cyc + 1);
        next++;
      end
      @(posedge clk);
      #2;
      cyc++;
      core_req = '0;
      if (next < BURST_LEN) begin
        core_req.data_req = 1'b1;
        core_req.addr     = burst_addr[next];
      end
    end
    if (granted_q.size() != 0) begin
      report_failure($sformatf("%s sent memory requests for cached lines", name));
    end
  endtask

  // --------------------
  // miss unit model
  // --------------------
  initial begin : miss_unit
    int unsigned gnt_wait;
    int unsigned rsp_wait;
    int unsigned base;
    logic        gnt_armed;
    logic        rsp_pending;
    miss_req_t   taken;

    miss_gnt     = 1'b0;
    bypass_gnt   = 1'b0;
    refill_valid = 1'b0;
    refill_line  = '0;
    bypass_valid = 1'b0;
    bypass_data  = '0;
    gnt_wait     = 0;
    rsp_wait     = 0;
    gnt_armed    = 1'b0;
    rsp_pending  = 1'b0;
    taken        = '0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      ext_mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #2;
      miss_gnt     = 1'b0;
      bypass_gnt   = 1'b0;
      refill_valid = 1'b0;
      bypass_valid = 1'b0;
      if (rsp_pending) begin
        if (rsp_wait == 0) begin
          rsp_pending = 1'b0;
          if (taken.bypass) begin
            bypass_valid = 1'b1;
            bypass_data  = ext_mem[mem_index(taken.addr)];
          end else begin
            // first word of the line
            base                 = mem_index(taken.addr) & ~32'd1;
            refill_valid         = 1'b1;
            refill_line.words[0] = ext_mem[base];
            refill_line.words[1] = ext_mem[base + 1];
          end
        end else begin
          rsp_wait--;
        end
      end else if (miss_req.valid) begin
        if (!gnt_armed) begin
          gnt_wait  = $urandom_range(3, 0);
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0) begin
          gnt_armed = 1'b0;
          taken     = miss_req;
          granted_q.push_back(taken);
          if (taken.bypass) begin
            bypass_gnt = 1'b1;
          end else begin
            miss_gnt = 1'b1;
          end
          if (taken.we) begin
            ext_mem[mem_index(taken.addr)] = merge_bytes(ext_mem[mem_index(taken.addr)],
                                                         taken.wdata, taken.be);
          end else begin
            // data follows 1 to 4 cycles after the grant
            rsp_pending = 1'b1;
            rsp_wait    = $urandom_range(3, 0);
          end
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure($sformatf("timeout after %0d cycles, the cache stopped answering",
                                 cycles));
      end
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin : main_test
    logic        saw_hit;
    int unsigned lat;
    addr_t       addr;
    addr_t       cold_addr [NUM_COLD];
    addr_t       warm_addr [NUM_WARM];

    void'($urandom(32'ha740));
    bypass_mode = 1'b0;
    core_req    = '0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    @(posedge rst_n);
    // nothing is outstanding straight after reset
    @(negedge clk);
    check_bit("reset data_gnt", 1'b0, core_rsp.data_gnt);
    check_bit("reset data_rvalid", 1'b0, core_rsp.data_rvalid);
    check_bit("reset miss valid", 1'b0, miss_req.valid);
    check_bit("reset hit", 1'b0, hit);
    check_bit("reset busy", 1'b0, busy);
    repeat (2) @(posedge clk);
    #2;

    // bypass phase, arrays stay untouched
    bypass_mode = 1'b1;
    for (int unsigned i = 0; i < NUM_BYPASS; i++) begin
      addr = index_addr($urandom_range(MEM_WORDS - 1, 0));
      if ($urandom_range(1, 0) == 1) begin
        store_word($sformatf("bypass store %0d", i), addr, be_t'($urandom()), rand_word());
      end else begin
        load_word($sformatf("bypass load %0d", i), addr, saw_hit, lat);
        if (saw_hit) begin
          report_failure($sformatf("hit_o pulsed for bypass load %0d", i));
        end
      end
    end
    @(posedge clk);
    #2;
    bypass_mode = 1'b0;

    // cold miss then reload, lines 0 3 6 9 in separate sets
    for (int unsigned k = 0; k < NUM_COLD; k++) begin
      cold_addr[k] = index_addr(6 * k + $urandom_range(1, 0));
      load_word($sformatf("cold load %0d", k), cold_addr[k], saw_hit, lat);
      if (saw_hit) begin
        report_failure($sformatf("cold load %0d hit in an empty cache", k));
      end
      load_word($sformatf("reload %0d", k), cold_addr[k], saw_hit, lat);
      if (!saw_hit || lat != 1) begin
        report_failure($sformatf("reload %0d was not a one-cycle hit", k));
      end
    end

    // store hit on the same lines, then read back the merged word
    for (int unsigned k = 0; k < NUM_COLD; k++) begin
      addr = index_addr(6 * k + $urandom_range(1, 0));
      store_word($sformatf("store hit %0d", k), addr, be_t'($urandom_range(255, 1)),
                 rand_word());
      load_word($sformatf("load after store hit %0d", k), addr, saw_hit, lat);
      if (!saw_hit) begin
        report_failure($sformatf("load after store hit %0d missed the cache", k));
      end
    end

    // warm lines 10 to 15, then hit them back to back
    for (int unsigned k = 0; k < NUM_WARM; k++) begin
      warm_addr[k] = index_addr(2 * (10 + k) + $urandom_range(1, 0));
      load_word($sformatf("warm load %0d", k), warm_addr[k], saw_hit, lat);
    end
    for (int unsigned j = 0; j < BURST_LEN; j++) begin
      burst_addr[j] = warm_addr[$urandom_range(NUM_WARM - 1, 0)];
    end
    load_burst("hit burst");

    // four lines per set over two ways forces evictions
    for (int unsigned i = 0; i < NUM_MIXED; i++) begin
      addr = index_addr($urandom_range(MEM_WORDS - 1, 0));
      if ($urandom_range(9, 0) < 6) begin
        load_word($sformatf("mixed load %0d", i), addr, saw_hit, lat);
      end else begin
        store_word($sformatf("mixed store %0d", i), addr, be_t'($urandom()), rand_word());
      end
    end

    repeat (2) @(posedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule
